// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_sdram_subsys
FILELIST   := build.f
SIM_FLAGS  := --binary --assert --timing -Wno-fatal
LINT_FLAGS := --lint-only --assert --timing -Wall
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := Some tests failed
PASS_MSG   := All tests passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
+incdir+src
src/sdram_pkg.sv
src/sdram_timer.sv
src/sdram_ctrl_fsm.sv
src/sdram_datapath.sv
src/sdram_model.sv
src/sdram_subsys.sv
verification/tb_sdram_subsys.sv

// File: src/sdram_cfg.svh
`ifndef SDRAM_CFG_SVH
`define SDRAM_CFG_SVH

// Device geometry
`define SDRAM_ROW_BITS    13
`define SDRAM_COL_BITS    9
`define SDRAM_BANKS       4

// Reduced array inside the behavioral device
`define SDRAM_MODEL_ROWS  16
`define SDRAM_MODEL_COLS  32

// Mode register contents
`define SDRAM_BURST_LEN   4
`define SDRAM_CAS_LAT     2

// Timing in clock cycles, short power-up wait for simulation
`define SDRAM_T_INIT      20
`define SDRAM_T_RCD       2
`define SDRAM_T_RP        2
`define SDRAM_T_RFC       6
`define SDRAM_T_REFI      150

`endif

// File: src/sdram_ctrl_fsm.sv
`timescale 1ns/100ps
`include "sdram_cfg.svh"

module sdram_ctrl_fsm (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req,
    input  sdram_pkg::sdram_req_t  req_data,
    output logic                   ready,
    output sdram_pkg::sdram_pins_t pins,
    output logic                   load,
    output logic                   wr_beat,
    output logic                   rd_issue,
    output logic                   gap_load,
    output logic [7:0]             gap_len,
    input  logic                   gap_done,
    input  logic                   refresh_due,
    output logic                   refresh_ack
);

    localparam int BEAT_W = $clog2(`SDRAM_BURST_LEN);
    localparam int BANK_W = $clog2(`SDRAM_BANKS);
    localparam logic [BEAT_W-1:0] BEAT_ONE  = BEAT_W'(1);
    localparam logic [BEAT_W-1:0] BEAT_LAST = BEAT_W'(`SDRAM_BURST_LEN - 1);
    // Sequential burst, CAS latency in a[6:4], burst code in a[2:0]
    localparam logic [`SDRAM_ROW_BITS-1:0] MODE_WORD = {
        {(`SDRAM_ROW_BITS - 7){1'b0}}, 3'(`SDRAM_CAS_LAT), 1'b0, 3'($clog2(`SDRAM_BURST_LEN))
    };

    sdram_pkg::sdram_state_e     state;
    sdram_pkg::sdram_state_e     state_nxt;
    sdram_pkg::sdram_cmd_e       cmd;
    logic [BANK_W-1:0]           cmd_ba;
    logic [`SDRAM_ROW_BITS-1:0]  cmd_a;
    logic                        init_ref_cnt;
    logic [BEAT_W-1:0]           beat_cnt;

    // Accepted request address
    logic                        acc_write;
    logic [BANK_W-1:0]           acc_bank;
    logic [`SDRAM_ROW_BITS-1:0]  acc_row;
    logic [`SDRAM_COL_BITS-1:0]  acc_col;

    assign ready = (state == sdram_pkg::ST_IDLE) && !refresh_due;

    always_comb begin
        state_nxt   = state;
        cmd         = sdram_pkg::CMD_NOP;
        cmd_ba      = '0;
        cmd_a       = '0;
        gap_load    = 1'b0;
        gap_len     = 8'd0;
        load        = 1'b0;
        wr_beat     = 1'b0;
        rd_issue    = 1'b0;
        refresh_ack = 1'b0;
        case (state)
            sdram_pkg::ST_INIT_WAIT: begin
                if (gap_done) begin
                    state_nxt = sdram_pkg::ST_INIT_PRE;
                end
            end
            sdram_pkg::ST_INIT_PRE: begin
                // Close all banks with a10
                cmd       = sdram_pkg::CMD_PRECHARGE;
                cmd_a[10] = 1'b1;
                gap_load  = 1'b1;
                gap_len   = 8'(`SDRAM_T_RP - 1);
                state_nxt = sdram_pkg::ST_INIT_REF;
            end
            sdram_pkg::ST_INIT_REF: begin
                if (gap_done) begin
                    cmd      = sdram_pkg::CMD_AUTO_REFRESH;
                    gap_load = 1'b1;
                    gap_len  = 8'(`SDRAM_T_RFC - 1);
                    // Second refresh ends this phase
                    if (init_ref_cnt) begin
                        state_nxt = sdram_pkg::ST_INIT_MRS;
                    end
                end
            end
            sdram_pkg::ST_INIT_MRS: begin
                if (gap_done) begin
                    cmd       = sdram_pkg::CMD_LOAD_MODE;
                    cmd_a     = MODE_WORD;
                    gap_load  = 1'b1;
                    gap_len   = 8'd1;
                    state_nxt = sdram_pkg::ST_GAP;
                end
            end
            sdram_pkg::ST_IDLE: begin
                // Refresh takes priority over a new request
                if (refresh_due) begin
                    state_nxt = sdram_pkg::ST_REFRESH;
                end else if (req) begin
                    load      = 1'b1;
                    state_nxt = sdram_pkg::ST_ACTIVATE;
                end
            end
            sdram_pkg::ST_REFRESH: begin
                cmd         = sdram_pkg::CMD_AUTO_REFRESH;
                refresh_ack = 1'b1;
                gap_load    = 1'b1;
                gap_len     = 8'(`SDRAM_T_RFC - 1);
                state_nxt   = sdram_pkg::ST_GAP;
            end
            sdram_pkg::ST_ACTIVATE: begin
                cmd       = sdram_pkg::CMD_ACTIVE;
                cmd_ba    = acc_bank;
                cmd_a     = acc_row;
                gap_load  = 1'b1;
                gap_len   = 8'(`SDRAM_T_RCD - 1);
                state_nxt = sdram_pkg::ST_RW;
            end
            sdram_pkg::ST_RW: begin
                // Waits out tRCD, a10 low so no auto precharge
                if (gap_done) begin
                    cmd = acc_write ? sdram_pkg::CMD_WRITE : sdram_pkg::CMD_READ;
                    cmd_ba = acc_bank;
                    cmd_a[`SDRAM_COL_BITS-1:0] = acc_col;
                    wr_beat   = acc_write;
                    rd_issue  = !acc_write;
                    state_nxt = sdram_pkg::ST_BURST;
                end
            end
            sdram_pkg::ST_BURST: begin
                // Remaining beats, reads just let the burst run
                wr_beat = acc_write;
                if (beat_cnt == BEAT_LAST) begin
                    state_nxt = sdram_pkg::ST_PRECHARGE;
                end
            end
            sdram_pkg::ST_PRECHARGE: begin
                cmd       = sdram_pkg::CMD_PRECHARGE;
                cmd_ba    = acc_bank;
                gap_load  = 1'b1;
                gap_len   = 8'(`SDRAM_T_RP - 1);
                state_nxt = sdram_pkg::ST_GAP;
            end
            sdram_pkg::ST_GAP: begin
                if (gap_done) begin
                    state_nxt = sdram_pkg::ST_IDLE;
                end
            end
            default: begin
                state_nxt = sdram_pkg::ST_INIT_WAIT;
            end
        endcase
    end

    always_comb begin
        pins = '0;
        {pins.cs_n, pins.ras_n, pins.cas_n, pins.we_n} = sdram_pkg::cmd_pins(cmd);
        pins.ba = cmd_ba;
        pins.a  = cmd_a;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= sdram_pkg::ST_INIT_WAIT;
            init_ref_cnt <= 1'b0;
            beat_cnt     <= '0;
        end else begin
            state <= state_nxt;
            if (state == sdram_pkg::ST_INIT_REF && gap_done) begin
                init_ref_cnt <= 1'b1;
            end
            // Beat 0 goes with the command itself
            if (state == sdram_pkg::ST_RW) begin
                beat_cnt <= BEAT_ONE;
            end else if (state == sdram_pkg::ST_BURST) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            acc_write <= req_data.write;
            acc_bank  <= req_data.bank;
            acc_row   <= req_data.row;
            acc_col   <= req_data.col;
        end
    end

endmodule

// File: src/sdram_datapath.sv
`timescale 1ns/100ps
`include "sdram_cfg.svh"

module sdram_datapath (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           load,
    input  logic                           wr_beat,
    input  logic                           rd_issue,
    input  sdram_pkg::sdram_req_t          req_data,
    output logic [15:0]                    dq_wr,
    output logic [1:0]                     dqm,
    input  logic [15:0]                    dq_rd,
    input  logic                           dq_oe,
    output logic                           rsp_valid,
    output logic [`SDRAM_BURST_LEN*16-1:0] rdata
);

    localparam int BL    = `SDRAM_BURST_LEN;
    localparam int CL    = `SDRAM_CAS_LAT;
    localparam int IDX_W = $clog2(BL);
    localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(BL - 1);

    logic [BL-1:0][15:0] wr_data_q;
    logic [BL-1:0][1:0]  wr_mask_q;
    logic [BL-1:0][15:0] rdata_q;
    logic [CL-1:0]       rd_pipe;
    logic                cap_on;
    logic [IDX_W-1:0]    cap_idx;
    logic                cap_start;
    logic                window;
    logic [IDX_W-1:0]    beat_idx;

    // Write shifter, current beat always in slot 0
    always_ff @(posedge clk) begin
        if (load) begin
            wr_data_q <= req_data.wdata;
            wr_mask_q <= req_data.wmask;
        end else if (wr_beat) begin
            wr_data_q <= {16'h0000, wr_data_q[BL-1:1]};
            // Emptied slots keep every byte
            wr_mask_q <= {2'b11, wr_mask_q[BL-1:1]};
        end
    end

    assign dq_wr = wr_data_q[0];
    assign dqm   = wr_mask_q[0];

    // Read command reaches the end of the pipe with beat 0 on dq_rd
    assign cap_start = rd_pipe[CL-1];
    assign window    = cap_start | cap_on;
    assign beat_idx  = cap_start ? '0 : cap_idx;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_pipe   <= '0;
            cap_on    <= 1'b0;
            cap_idx   <= '0;
            rsp_valid <= 1'b0;
        end else begin
            rd_pipe   <= {rd_pipe[CL-2:0], rd_issue};
            rsp_valid <= window && (beat_idx == IDX_LAST);
            if (cap_start) begin
                cap_on  <= 1'b1;
                cap_idx <= IDX_W'(1);
            end else if (cap_on) begin
                cap_idx <= cap_idx + 1'b1;
                if (cap_idx == IDX_LAST) begin
                    cap_on <= 1'b0;
                end
            end
        end
    end

    // Beat store, holds until the next read
    always_ff @(posedge clk) begin
        if (window && dq_oe) begin
            rdata_q[beat_idx] <= dq_rd;
        end
    end

    assign rdata = rdata_q;

endmodule

// File: src/sdram_model.sv
`timescale 1ns/100ps
`include "sdram_cfg.svh"

module sdram_model (
    input  logic                   clk,
    input  logic                   rst_n,
    input  sdram_pkg::sdram_pins_t pins,
    input  logic [1:0]             dqm,
    input  logic [15:0]            dq_wr,
    output logic [15:0]            dq_rd,
    output logic                   dq_oe
);

    localparam int BANKS  = `SDRAM_BANKS;
    localparam int BANK_W = $clog2(`SDRAM_BANKS);
    localparam int ROW_W  = $clog2(`SDRAM_MODEL_ROWS);
    localparam int COL_W  = $clog2(`SDRAM_MODEL_COLS);

    logic [15:0] mem [BANKS][`SDRAM_MODEL_ROWS][`SDRAM_MODEL_COLS];

    sdram_pkg::sdram_cmd_e       cmd;
    // Mode register
    logic [3:0]                  burst_len;
    logic [2:0]                  cas_lat;
    // Open row per bank
    logic [BANKS-1:0]            row_open;
    logic [`SDRAM_ROW_BITS-1:0]  open_row [BANKS];
    // Read burst per bank
    logic [2:0]                  rd_wait [BANKS];
    logic [3:0]                  rd_left [BANKS];
    logic [COL_W-1:0]            rd_col [BANKS];
    logic [ROW_W-1:0]            rd_row [BANKS];
    logic                        rd_hit;
    logic [BANK_W-1:0]           rd_sel;
    // Write burst
    logic [3:0]                  wr_left;
    logic [BANK_W-1:0]           wr_bank;
    logic [COL_W-1:0]            wr_col;
    logic                        wr_en;
    logic [BANK_W-1:0]           wr_b;
    logic [COL_W-1:0]            wr_c;
    logic [ROW_W-1:0]            wr_r;

    // Pin decode, deselect counts as NOP
    always_comb begin
        case ({pins.cs_n, pins.ras_n, pins.cas_n, pins.we_n})
            4'b0011: cmd = sdram_pkg::CMD_ACTIVE;
            4'b0101: cmd = sdram_pkg::CMD_READ;
            4'b0100: cmd = sdram_pkg::CMD_WRITE;
            4'b0010: cmd = sdram_pkg::CMD_PRECHARGE;
            4'b0001: cmd = sdram_pkg::CMD_AUTO_REFRESH;
            4'b0000: cmd = sdram_pkg::CMD_LOAD_MODE;
            default: cmd = sdram_pkg::CMD_NOP;
        endcase
    end

    // Beat 0 straight from the WRITE pins, later beats from the burst state
    always_comb begin
        wr_en = 1'b0;
        wr_b  = wr_bank;
        wr_c  = wr_col;
        if (cmd == sdram_pkg::CMD_WRITE && row_open[pins.ba]) begin
            wr_en = 1'b1;
            wr_b  = pins.ba;
            wr_c  = pins.a[COL_W-1:0];
        end else if (wr_left != 4'd0) begin
            wr_en = 1'b1;
        end
        wr_r = open_row[wr_b][ROW_W-1:0];
    end

    // Bank with a beat due next cycle
    always_comb begin
        rd_hit = 1'b0;
        rd_sel = '0;
        for (int b = 0; b < BANKS; b++) begin
            if (rd_left[b] != 4'd0 && rd_wait[b] <= 3'd1) begin
                rd_hit = 1'b1;
                rd_sel = BANK_W'(b);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            burst_len <= 4'd1;
            cas_lat   <= 3'd1;
            row_open  <= '0;
            wr_left   <= 4'd0;
            wr_bank   <= '0;
            wr_col    <= '0;
            dq_oe     <= 1'b0;
            for (int b = 0; b < BANKS; b++) begin
                open_row[b] <= '0;
                rd_wait[b]  <= 3'd0;
                rd_left[b]  <= 4'd0;
                rd_col[b]   <= '0;
                rd_row[b]   <= '0;
            end
        end else begin
            dq_oe <= rd_hit;
            case (cmd)
                sdram_pkg::CMD_LOAD_MODE: begin
                    burst_len <= 4'd1 << pins.a[1:0];
                    cas_lat   <= pins.a[6:4];
                end
                sdram_pkg::CMD_ACTIVE: begin
                    row_open[pins.ba] <= 1'b1;
                    open_row[pins.ba] <= pins.a;
                end
                sdram_pkg::CMD_PRECHARGE: begin
                    // a10 closes every bank
                    if (pins.a[10]) begin
                        row_open <= '0;
                    end else begin
                        row_open[pins.ba] <= 1'b0;
                    end
                end
                default: begin
                end
            endcase
            if (cmd == sdram_pkg::CMD_WRITE && row_open[pins.ba]) begin
                wr_left <= burst_len - 4'd1;
                wr_bank <= pins.ba;
                wr_col  <= pins.a[COL_W-1:0] + 1'b1;
            end else if (wr_left != 4'd0) begin
                wr_left <= wr_left - 4'd1;
                wr_col  <= wr_col + 1'b1;
            end
            for (int b = 0; b < BANKS; b++) begin
                if (cmd == sdram_pkg::CMD_READ && int'(pins.ba) == b && row_open[b]) begin
                    // Row latched so a precharge mid-burst does not disturb it
                    rd_wait[b] <= cas_lat - 3'd1;
                    rd_left[b] <= burst_len;
                    rd_col[b]  <= pins.a[COL_W-1:0];
                    rd_row[b]  <= open_row[b][ROW_W-1:0];
                end else if (rd_left[b] != 4'd0) begin
                    if (rd_wait[b] > 3'd1) begin
                        rd_wait[b] <= rd_wait[b] - 3'd1;
                    end else begin
                        rd_left[b] <= rd_left[b] - 4'd1;
                        rd_col[b]  <= rd_col[b] + 1'b1;
                    end
                end
            end
        end
    end

    // Array access, dqm high masks the byte
    always_ff @(posedge clk) begin
        if (wr_en) begin
            if (!dqm[0]) begin
                mem[wr_b][wr_r][wr_c][7:0] <= dq_wr[7:0];
            end
            if (!dqm[1]) begin
                mem[wr_b][wr_r][wr_c][15:8] <= dq_wr[15:8];
            end
        end
        if (rd_hit) begin
            dq_rd <= mem[rd_sel][rd_row[rd_sel]][rd_col[rd_sel]];
        end
    end

endmodule

// File: src/sdram_pkg.sv
`include "sdram_cfg.svh"

package sdram_pkg;

    // Commands on the pins
    typedef enum logic [2:0] {
        CMD_NOP, CMD_ACTIVE, CMD_READ, CMD_WRITE,
        CMD_PRECHARGE, CMD_AUTO_REFRESH, CMD_LOAD_MODE
    } sdram_cmd_e;

    // Controller sequencer states
    typedef enum logic [3:0] {
        ST_INIT_WAIT, ST_INIT_PRE, ST_INIT_REF, ST_INIT_MRS, ST_IDLE, ST_REFRESH,
        ST_ACTIVATE, ST_RW, ST_BURST, ST_PRECHARGE, ST_GAP
    } sdram_state_e;

    typedef struct packed {
        logic                               cs_n;
        logic                               ras_n;
        logic                               cas_n;
        logic                               we_n;
        logic [$clog2(`SDRAM_BANKS)-1:0]    ba;
        logic [`SDRAM_ROW_BITS-1:0]         a;
    } sdram_pins_t;

    // One burst request, wmask bit set keeps that byte
    typedef struct packed {
        logic                               write;
        logic [$clog2(`SDRAM_BANKS)-1:0]    bank;
        logic [`SDRAM_ROW_BITS-1:0]         row;
        logic [`SDRAM_COL_BITS-1:0]         col;
        logic [`SDRAM_BURST_LEN-1:0][15:0]  wdata;
        logic [`SDRAM_BURST_LEN-1:0][1:0]   wmask;
    } sdram_req_t;

    // Levels of cs_n, ras_n, cas_n, we_n
    function automatic logic [3:0] cmd_pins(input sdram_cmd_e cmd);
        case (cmd)
            CMD_ACTIVE:       return 4'b0011;
            CMD_READ:         return 4'b0101;
            CMD_WRITE:        return 4'b0100;
            CMD_PRECHARGE:    return 4'b0010;
            CMD_AUTO_REFRESH: return 4'b0001;
            CMD_LOAD_MODE:    return 4'b0000;
            default:          return 4'b0111;
        endcase
    endfunction

endpackage

// File: src/sdram_subsys.sv
`timescale 1ns/100ps
`include "sdram_cfg.svh"

module sdram_subsys (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           req,
    input  sdram_pkg::sdram_req_t          req_data,
    output logic                           ready,
    output logic                           rsp_valid,
    output logic [`SDRAM_BURST_LEN*16-1:0] rdata
);

    sdram_pkg::sdram_pins_t pins;
    logic        load;
    logic        wr_beat;
    logic        rd_issue;
    logic        gap_load;
    logic [7:0]  gap_len;
    logic        gap_done;
    logic        refresh_due;
    logic        refresh_ack;
    // Split data bus between controller and device
    logic [15:0] dq_wr;
    logic [1:0]  dqm;
    logic [15:0] dq_rd;
    logic        dq_oe;

    sdram_timer u_timer (
        .clk         (clk),
        .rst_n       (rst_n),
        .gap_load    (gap_load),
        .gap_len     (gap_len),
        .gap_done    (gap_done),
        .refresh_ack (refresh_ack),
        .refresh_due (refresh_due)
    );

    sdram_ctrl_fsm u_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .req_data    (req_data),
        .ready       (ready),
        .pins        (pins),
        .load        (load),
        .wr_beat     (wr_beat),
        .rd_issue    (rd_issue),
        .gap_load    (gap_load),
        .gap_len     (gap_len),
        .gap_done    (gap_done),
        .refresh_due (refresh_due),
        .refresh_ack (refresh_ack)
    );

    sdram_datapath u_datapath (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (load),
        .wr_beat   (wr_beat),
        .rd_issue  (rd_issue),
        .req_data  (req_data),
        .dq_wr     (dq_wr),
        .dqm       (dqm),
        .dq_rd     (dq_rd),
        .dq_oe     (dq_oe),
        .rsp_valid (rsp_valid),
        .rdata     (rdata)
    );

    sdram_model u_model (
        .clk   (clk),
        .rst_n (rst_n),
        .pins  (pins),
        .dqm   (dqm),
        .dq_wr (dq_wr),
        .dq_rd (dq_rd),
        .dq_oe (dq_oe)
    );

endmodule

// File: src/sdram_timer.sv
`timescale 1ns/100ps
`include "sdram_cfg.svh"

module sdram_timer (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       gap_load,
    input  logic [7:0] gap_len,
    output logic       gap_done,
    input  logic       refresh_ack,
    output logic       refresh_due
);

    localparam int REFI_W = $clog2(`SDRAM_T_REFI);
    localparam logic [REFI_W-1:0] REFI_LAST = REFI_W'(`SDRAM_T_REFI - 1);

    logic [7:0]        gap_cnt;
    logic [REFI_W-1:0] refi_cnt;

    // Gap counter starts out holding the power-up wait
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gap_cnt <= 8'(`SDRAM_T_INIT - 1);
        end else if (gap_load) begin
            gap_cnt <= gap_len;
        end else if (gap_cnt != 8'd0) begin
            gap_cnt <= gap_cnt - 8'd1;
        end
    end

    assign gap_done = (gap_cnt == 8'd0);

    // Free-running refresh interval
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            refi_cnt    <= '0;
            refresh_due <= 1'b0;
        end else if (refi_cnt == REFI_LAST) begin
            refi_cnt    <= '0;
            refresh_due <= 1'b1;
        end else begin
            refi_cnt <= refi_cnt + 1'b1;
            // Held until the FSM issues the refresh
            if (refresh_ack) begin
                refresh_due <= 1'b0;
            end
        end
    end

endmodule

// File: verification/tb_sdram_subsys.sv
`timescale 1ns/100ps
`include "sdram_cfg.svh"

module tb_sdram_subsys;

    localparam int BL          = `SDRAM_BURST_LEN;
    localparam int ROWS        = `SDRAM_MODEL_ROWS;
    localparam int COLS        = `SDRAM_MODEL_COLS;
    localparam int GROUPS      = COLS / BL;
    localparam int DATA_W      = BL * 16;
    localparam int MASK_W      = BL * 2;
    localparam int MIN_INIT    = `SDRAM_T_INIT + `SDRAM_T_RP + 2 * `SDRAM_T_RFC + 2;
    localparam int IDLE_CYC    = 3 * `SDRAM_T_REFI + 20;
    localparam int NUM_OPS     = 200;
    localparam int NUM_REQ     = NUM_OPS + 40;
    localparam int TIMEOUT_CYC = MIN_INIT + IDLE_CYC + 200 * NUM_REQ;
    localparam logic [31:0] SEED = 32'h13576f41;

    logic                  clk;
    logic                  rst_n;
    logic                  req;
    sdram_pkg::sdram_req_t req_data;
    logic                  ready;
    logic                  rsp_valid;
    logic [DATA_W-1:0]     rdata;

    // Reference memory, same reduced geometry as the device
    logic [15:0]       ref_mem [`SDRAM_BANKS][ROWS][COLS];
    // Burst groups holding fully defined data
    logic              written [`SDRAM_BANKS][ROWS][GROUPS];
    logic [DATA_W-1:0] exp_rdata;
    int                outstanding;
    int                rsp_count;
    int                reads_issued;
    int                cyc;
    int                drops;

    sdram_subsys uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .req_data  (req_data),
        .ready     (ready),
        .rsp_valid (rsp_valid),
        .rdata     (rdata)
    );

    always #5 clk = ~clk;

    // Reads in flight, init cycle count and response count
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outstanding <= 0;
            rsp_count   <= 0;
            cyc         <= 0;
        end else begin
            outstanding <= outstanding + ((req && ready && !req_data.write) ? 1 : 0)
                           - (rsp_valid ? 1 : 0);
            if (rsp_valid) begin
                rsp_count <= rsp_count + 1;
            end
            if (cyc <= MIN_INIT) begin
                cyc <= cyc + 1;
            end
        end
    end

    // Quiet outputs through the whole init sequence
    init_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        (cyc <= MIN_INIT) |-> (!ready && !rsp_valid))
        else begin
            $display("ready or rsp_valid went high before init finished at %0t", $time);
            $display("Some tests failed");
            $fatal(1);
        end

    // One response per accepted read
    rsp_single: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid |-> (outstanding == 1))
        else begin
            $display("FAIL %0t outstanding expected 1 observed %0d", $time,
                     $sampled(outstanding));
            $display("Some tests failed");
            $fatal(1);
        end

    rdata_match: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid |-> (rdata == exp_rdata))
        else begin
            $display("FAIL %0t rdata expected %h observed %h", $time,
                     $sampled(exp_rdata), $sampled(rdata));
            $display("Some tests failed");
            $fatal(1);
        end

    // Mask bit set keeps the stored byte
    function automatic logic [15:0] merge_beat(input logic [15:0] old_val,
                                               input logic [15:0] new_val,
                                               input logic [1:0]  keep);
        merge_beat[7:0]  = keep[0] ? old_val[7:0] : new_val[7:0];
        merge_beat[15:8] = keep[1] ? old_val[15:8] : new_val[15:8];
    endfunction

    function automatic logic [DATA_W-1:0] expected_burst(input int bank, input int row,
                                                         input int col);
        logic [DATA_W-1:0] result;
        for (int i = 0; i < BL; i++) begin
            result[16*i +: 16] = ref_mem[bank][row][col+i];
        end
        return result;
    endfunction

    // Waits for ready at drive time, then a one-cycle strobe
    task automatic send_request(input logic write, input int bank, input int row,
                                input int col, input logic [DATA_W-1:0] data,
                                input logic [MASK_W-1:0] keep);
        do begin
            @(posedge clk);
            #1;
        end while (!ready);
        req            = 1'b1;
        req_data.write = write;
        req_data.bank  = 2'(bank);
        req_data.row   = 13'(row);
        req_data.col   = 9'(col);
        req_data.wdata = data;
        req_data.wmask = keep;
        @(posedge clk);
        #1;
        req = 1'b0;
    endtask

    task automatic write_burst(input int bank, input int row, input int col,
                               input logic [DATA_W-1:0] data, input logic [MASK_W-1:0] keep);
        for (int i = 0; i < BL; i++) begin
            ref_mem[bank][row][col+i] = merge_beat(ref_mem[bank][row][col+i],
                                                   data[16*i +: 16], keep[2*i +: 2]);
        end
        if (keep == '0) begin
            written[bank][row][col/BL] = 1'b1;
        end
        send_request(1'b1, bank, row, col, data, keep);
    endtask

    task automatic read_burst(input int bank, input int row, input int col);
        exp_rdata = expected_burst(bank, row, col);
        send_request(1'b0, bank, row, col, '0, '0);
        reads_issued++;
        do begin
            @(posedge clk);
            #1;
            // Stray strobe while busy, has to be dropped
            req = !ready && ($urandom_range(7) == 0);
        end while (!rsp_valid);
        req = 1'b0;
        // Let the check edge pass before exp_rdata moves on
        @(posedge clk);
        #1;
    endtask

    task automatic read_all_written();
        for (int b = 0; b < `SDRAM_BANKS; b++) begin
            for (int r = 0; r < ROWS; r++) begin
                for (int g = 0; g < GROUPS; g++) begin
                    if (written[b][r][g]) begin
                        read_burst(b, r, g * BL);
                    end
                end
            end
        end
    endtask

    initial begin
        #(TIMEOUT_CYC * 10);
        $display("Run timed out waiting for the DUT at %0t", $time);
        $display("Some tests failed");
        $fatal(1);
    end

    initial begin
        int bank;
        int row;
        int grp;
        int banks_q [4];
        int rows_q [4];
        void'($urandom(SEED));
        clk          = 1'b0;
        rst_n        = 1'b0;
        req          = 1'b0;
        req_data     = '0;
        exp_rdata    = '0;
        reads_issued = 0;
        drops        = 0;
        for (int b = 0; b < `SDRAM_BANKS; b++) begin
            for (int r = 0; r < ROWS; r++) begin
                for (int g = 0; g < GROUPS; g++) begin
                    written[b][r][g] = 1'b0;
                end
            end
        end
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Plain write then read back, first request also waits out init
        write_burst(0, 3, 8, {$urandom, $urandom}, '0);
        read_burst(0, 3, 8);

        // Masked bytes hold the old data
        write_burst(1, 5, 16, {$urandom, $urandom}, '0);
        write_burst(1, 5, 16, {$urandom, $urandom}, 8'b10_01_00_11);
        read_burst(1, 5, 16);

        // Same row in several banks, several rows in one bank
        banks_q = '{2, 3, 2, 0};
        rows_q  = '{7, 7, 9, 7};
        for (int i = 0; i < 4; i++) begin
            write_burst(banks_q[i], rows_q[i], 0, {$urandom, $urandom}, '0);
        end
        for (int i = 3; i >= 0; i--) begin
            read_burst(banks_q[i], rows_q[i], 0);
        end

        // Idle across several refresh intervals
        repeat (IDLE_CYC) begin
            @(posedge clk);
            #1;
            if (!ready) begin
                drops++;
            end
        end
        refresh_seen: assert (drops > 0)
            else begin
                $display("ready never dropped for a refresh during the idle stretch");
                $display("Some tests failed");
                $fatal(1);
            end
        read_all_written();

        // Random mix, undefined groups get a full write first
        for (int n = 0; n < NUM_OPS; n++) begin
            bank = $urandom_range(`SDRAM_BANKS - 1);
            row  = $urandom_range(ROWS - 1);
            grp  = $urandom_range(GROUPS - 1);
            if (!written[bank][row][grp]) begin
                write_burst(bank, row, grp * BL, {$urandom, $urandom}, '0);
            end else if ($urandom_range(1) == 0) begin
                write_burst(bank, row, grp * BL, {$urandom, $urandom}, MASK_W'($urandom));
            end else begin
                read_burst(bank, row, grp * BL);
            end
        end

        if (rsp_count == reads_issued) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("FAIL %0t rsp_valid count expected %0d observed %0d", $time,
                     reads_issued, rsp_count);
            $display("Some tests failed");
            $fatal(1);
        end
    end

endmodule
